// ==== include/list_consts.svh ====
`ifndef LIST_CONSTS_SVH
`define LIST_CONSTS_SVH

`define LIST_DEPTH 4
`define TAG_W      2
`define INDEX_W    4
`define LEN_W      3
`define CMD_W      3

// line status codes
`define STS_INVALID 3'b000
`define STS_VALID   3'b001
`define STS_DIRTY   3'b010
`define STS_FETCH   3'b100
`define STS_EVICT   3'b110

// access commands
`define CMD_LOOKUP_WR  3'd0
`define CMD_LOOKUP_RD  3'd1
`define CMD_ALLOC      3'd2
`define CMD_WB_DONE    3'd3
`define CMD_FILL_DIRTY 3'd4
`define CMD_FILL_CLEAN 3'd5

`endif

// ==== verilog/list_pkg.sv ====
`include "list_consts.svh"

package list_pkg;

    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`LEN_W-1:0]   len_t;
    typedef logic [`CMD_W-1:0]   cmd_t;

    typedef enum logic [2:0] {
        ST_INVALID = `STS_INVALID,
        ST_VALID   = `STS_VALID,
        ST_DIRTY   = `STS_DIRTY,
        ST_FETCH   = `STS_FETCH,
        ST_EVICT   = `STS_EVICT
    } line_status_e;

    typedef struct packed {
        logic   req;
        cmd_t   cmd;
        index_t index;
        tag_t   tag;
    } acc_req_t;

    typedef struct packed {
        logic         gnt;
        line_status_e status;
        tag_t         return_tag;
        index_t       return_index;
    } acc_rsp_t;

    // granted operation, flags already qualified by req and gnt
    typedef struct packed {
        logic   touch;
        logic   alloc_free;
        logic   alloc_evict;
        logic   mark_dirty;
        logic   wb_done;
        logic   fill_dirty;
        logic   fill_clean;
        tag_t   tgt;
        index_t index;
    } acc_op_t;

    typedef line_status_e [`LIST_DEPTH-1:0] entry_status_t;
    typedef index_t [`LIST_DEPTH-1:0]       entry_index_t;

endpackage

// ==== verilog/acc_decode.sv ====
`timescale 1ns/1ps
`include "list_consts.svh"

module acc_decode (
    input  list_pkg::acc_req_t      req,
    input  list_pkg::entry_status_t statuses,
    input  list_pkg::entry_index_t  indices,
    input  list_pkg::tag_t          free_tail,
    input  logic                    free_empty,
    input  list_pkg::tag_t          lru_tail,
    output logic                    gnt,
    output list_pkg::acc_op_t       op
);
    import list_pkg::*;

    logic         is_lookup;
    logic         is_lookup_wr;
    logic         is_alloc;
    logic         hit;
    tag_t         hit_tag;
    line_status_e hit_status;
    line_status_e tag_status;
    logic         tail_busy;
    logic         stall;
    logic         fire;

    assign is_lookup_wr = req.cmd == `CMD_LOOKUP_WR;
    assign is_lookup    = is_lookup_wr || req.cmd == `CMD_LOOKUP_RD;
    assign is_alloc     = req.cmd == `CMD_ALLOC;

    // fully associative match over live entries
    always_comb begin
        hit     = 1'b0;
        hit_tag = '0;
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            if (is_lookup && statuses[i] != ST_INVALID && indices[i] == req.index) begin
                hit     = 1'b1;
                hit_tag = tag_t'(i);
            end
        end
    end

    assign hit_status = statuses[hit_tag];
    assign tag_status = statuses[req.tag];

    // victim still waiting on a fill or a write-back
    assign tail_busy = statuses[lru_tail] == ST_FETCH || statuses[lru_tail] == ST_EVICT;

    assign stall = (is_alloc && free_empty && tail_busy) ||
                   (is_lookup_wr && hit && hit_status == ST_EVICT);

    assign gnt  = !(req.req && stall);
    assign fire = req.req && gnt;

    always_comb begin
        op             = '0;
        op.touch       = fire && hit;
        op.alloc_free  = fire && is_alloc && !free_empty;
        op.alloc_evict = fire && is_alloc && free_empty;
        op.mark_dirty  = fire && is_lookup_wr && hit && hit_status == ST_VALID;
        op.wb_done     = fire && req.cmd == `CMD_WB_DONE && tag_status == ST_EVICT;
        op.fill_dirty  = fire && req.cmd == `CMD_FILL_DIRTY && tag_status == ST_FETCH;
        op.fill_clean  = fire && req.cmd == `CMD_FILL_CLEAN && tag_status == ST_FETCH;
        op.index       = req.index;

        if (op.touch) begin
            op.tgt = hit_tag;
        end else if (op.alloc_free) begin
            op.tgt = free_tail;
        end else if (op.alloc_evict) begin
            op.tgt = lru_tail;
        end else if (op.wb_done || op.fill_dirty || op.fill_clean) begin
            op.tgt = req.tag;
        end
    end

endmodule

// ==== verilog/tag_state.sv ====
`timescale 1ns/1ps
`include "list_consts.svh"

module tag_state (
    input  logic                    clk,
    input  logic                    rst_n,
    input  list_pkg::acc_op_t       op,
    output list_pkg::entry_status_t statuses,
    output list_pkg::entry_index_t  indices
);
    import list_pkg::*;

    entry_status_t status_nxt;
    entry_index_t  index_nxt;

    always_comb begin
        status_nxt = statuses;
        index_nxt  = indices;
        for (int i = 0; i < `LIST_DEPTH; i++) begin
            if (op.tgt == tag_t'(i)) begin
                case (statuses[i])
                    ST_INVALID: begin
                        if (op.alloc_free) begin
                            status_nxt[i] = ST_FETCH;
                            index_nxt[i]  = op.index;
                        end
                    end
                    ST_VALID: begin
                        // clean victim is reused at once
                        if (op.alloc_evict) begin
                            status_nxt[i] = ST_FETCH;
                            index_nxt[i]  = op.index;
                        end else if (op.mark_dirty) begin
                            status_nxt[i] = ST_DIRTY;
                        end
                    end
                    ST_DIRTY: begin
                        // old index kept until write-back is done
                        if (op.alloc_evict) begin
                            status_nxt[i] = ST_EVICT;
                        end
                    end
                    ST_FETCH: begin
                        if (op.fill_dirty) begin
                            status_nxt[i] = ST_DIRTY;
                        end else if (op.fill_clean) begin
                            status_nxt[i] = ST_VALID;
                        end
                    end
                    ST_EVICT: begin
                        if (op.wb_done) begin
                            status_nxt[i] = ST_FETCH;
                            index_nxt[i]  = op.index;
                        end
                    end
                    default: begin
                        status_nxt[i] = statuses[i];
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LIST_DEPTH; i++) begin
                statuses[i] <= ST_INVALID;
                indices[i]  <= '0;
            end
        end else begin
            statuses <= status_nxt;
            indices  <= index_nxt;
        end
    end

endmodule

// ==== verilog/lru_lists.sv ====
`timescale 1ns/1ps
`include "list_consts.svh"

module lru_lists (
    input  logic              clk,
    input  logic              rst_n,
    input  list_pkg::acc_op_t op,
    output list_pkg::tag_t    free_tail,
    output logic              free_empty,
    output list_pkg::tag_t    lru_tail
);
    import list_pkg::*;

    // link tables shared by both lists
    tag_t prev_tag [`LIST_DEPTH];
    tag_t next_tag [`LIST_DEPTH];

    len_t free_len;
    tag_t lru_head;
    len_t lru_len;

    logic lru_empty;
    logic move;
    logic at_head;
    logic at_tail;
    tag_t tgt_prev;
    tag_t tgt_next;

    assign free_empty = free_len == '0;
    assign lru_empty  = lru_len == '0;

    assign move     = op.touch || op.alloc_evict;
    assign at_head  = op.tgt == lru_head;
    assign at_tail  = op.tgt == lru_tail;
    assign tgt_prev = prev_tag[op.tgt];
    assign tgt_next = next_tag[op.tgt];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // free list starts as a ring of all entries
            for (int i = 0; i < `LIST_DEPTH; i++) begin
                prev_tag[i] <= tag_t'((i + `LIST_DEPTH - 1) % `LIST_DEPTH);
                next_tag[i] <= tag_t'((i + 1) % `LIST_DEPTH);
            end
            free_tail <= tag_t'(`LIST_DEPTH - 1);
            free_len  <= len_t'(`LIST_DEPTH);
            lru_head  <= '0;
            lru_tail  <= '0;
            lru_len   <= '0;
        end else if (op.alloc_free) begin
            // free list is walked backwards from its tail
            free_tail <= tgt_prev;
            free_len  <= free_len - len_t'(1);

            // new entry becomes the recency head
            next_tag[op.tgt] <= lru_head;
            if (lru_empty) begin
                lru_tail <= op.tgt;
            end else begin
                prev_tag[lru_head] <= op.tgt;
            end
            lru_head <= op.tgt;
            lru_len  <= lru_len + len_t'(1);
        end else if (move && !at_head) begin
            // unlink
            if (at_tail) begin
                lru_tail <= tgt_prev;
            end else begin
                next_tag[tgt_prev] <= tgt_next;
                prev_tag[tgt_next] <= tgt_prev;
            end
            // and relink in front
            next_tag[op.tgt]   <= lru_head;
            prev_tag[lru_head] <= op.tgt;
            lru_head           <= op.tgt;
        end
    end

endmodule

// ==== verilog/acc_result.sv ====
`timescale 1ns/1ps

module acc_result (
    input  list_pkg::acc_op_t       op,
    input  list_pkg::entry_status_t statuses,
    input  list_pkg::entry_index_t  indices,
    output list_pkg::line_status_e  status,
    output list_pkg::index_t        return_index
);
    import list_pkg::*;

    logic report;

    assign report = op.touch || op.alloc_free || op.alloc_evict;

    // pre-update view of the target, so a dirty victim hands back its old index
    always_comb begin
        status       = ST_INVALID;
        return_index = '0;
        if (report) begin
            status       = statuses[op.tgt];
            return_index = indices[op.tgt];
        end
    end

endmodule

// ==== verilog/list_ctrl_top.sv ====
`timescale 1ns/1ps

module list_ctrl_top (
    input  logic               clk,
    input  logic               rst_n,
    input  list_pkg::acc_req_t req,
    output list_pkg::acc_rsp_t rsp
);
    import list_pkg::*;

    logic          gnt;
    acc_op_t       op;
    entry_status_t statuses;
    entry_index_t  indices;
    tag_t          free_tail;
    logic          free_empty;
    tag_t          lru_tail;
    line_status_e  status;
    index_t        return_index;

    acc_decode u_decode (
        .req        (req),
        .statuses   (statuses),
        .indices    (indices),
        .free_tail  (free_tail),
        .free_empty (free_empty),
        .lru_tail   (lru_tail),
        .gnt        (gnt),
        .op         (op)
    );

    tag_state u_tag_state (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op),
        .statuses (statuses),
        .indices  (indices)
    );

    lru_lists u_lru_lists (
        .clk        (clk),
        .rst_n      (rst_n),
        .op         (op),
        .free_tail  (free_tail),
        .free_empty (free_empty),
        .lru_tail   (lru_tail)
    );

    acc_result u_result (
        .op           (op),
        .statuses     (statuses),
        .indices      (indices),
        .status       (status),
        .return_index (return_index)
    );

    // tgt is zero when nothing took effect
    assign rsp.gnt          = gnt;
    assign rsp.status       = status;
    assign rsp.return_tag   = op.tgt;
    assign rsp.return_index = return_index;

endmodule

// ==== dv/list_ctrl_tb.sv ====
`timescale 1ns/1ps

module list_ctrl_tb;
    import list_pkg::*;

    localparam int MAX_VECS = 64;
    localparam int FIELDS   = 9;

    logic     clk;
    logic     rst_n;
    acc_req_t req;
    acc_rsp_t rsp;

    // one nibble per field, nine fields per vector
    logic [3:0] vec_mem [MAX_VECS*FIELDS];

    list_ctrl_top uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1: return "reset_miss";
            4'd2: return "alloc_free";
            4'd3: return "fill_and_dirty";
            4'd4: return "lru_evict";
            4'd5: return "dirty_victim";
            4'd6: return "alloc_stall";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_field(input string name, input int step, input string field,
                               input logic [3:0] expected, input logic [3:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s step %0d %s: expected %h, actual %h",
                     name, step, field, expected, actual);
            $display("Test failures found");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                report_failure("reset was not released within 20 cycles");
            end
        end
    endtask

    task automatic run_vector(input int step);
        int    base;
        string name;
        base = step * FIELDS;
        name = test_name(vec_mem[base]);
        @(posedge clk);
        #1;
        req.req   = vec_mem[base + 1][0];
        req.cmd   = cmd_t'(vec_mem[base + 2][2:0]);
        req.index = vec_mem[base + 3];
        req.tag   = vec_mem[base + 4][1:0];
        // sample just before the next edge
        #6;
        check_field(name, step, "gnt", vec_mem[base + 5], {3'b000, rsp.gnt});
        check_field(name, step, "status", vec_mem[base + 6], {1'b0, rsp.status});
        check_field(name, step, "return_tag", vec_mem[base + 7], {2'b00, rsp.return_tag});
        check_field(name, step, "return_index", vec_mem[base + 8], rsp.return_index);
    endtask

    initial begin
        int fd;
        int n_vecs;
        req = '0;
        // unused slots read as test id f, which ends the run
        for (int i = 0; i < MAX_VECS * FIELDS; i++) begin
            vec_mem[i] = 4'hf;
        end
        fd = $fopen("dv/list_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the stimulus file dv/list_stimulus.txt");
        end
        $fclose(fd);
        $readmemh("dv/list_stimulus.txt", vec_mem);

        n_vecs = 0;
        while (n_vecs < MAX_VECS && vec_mem[n_vecs * FIELDS] != 4'hf) begin
            n_vecs++;
        end
        if (n_vecs == 0) begin
            report_failure("the stimulus file holds no vectors");
        end

        wait_reset_release();
        for (int step = 0; step < n_vecs; step++) begin
            run_vector(step);
        end

        @(posedge clk);
        #1 req = '0;
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== dv/list_stimulus.txt ====
// columns: test req cmd index tag | expected gnt status return_tag return_index
// all hex, test 1 reset 2 alloc 3 fill 4 evict 5 dirty victim 6 stall
1 1 1 5 0 1 0 0 0
1 1 0 0 0 1 0 0 0
1 0 2 7 0 1 0 0 0
1 1 3 0 0 1 0 0 0
2 1 2 8 0 1 0 3 0
2 1 2 9 0 1 0 2 0
2 1 2 a 0 1 0 1 0
2 1 2 b 0 1 0 0 0
2 1 1 8 0 1 4 3 8
2 1 1 9 0 1 4 2 9
2 1 1 a 0 1 4 1 a
2 1 1 b 0 1 4 0 b
3 1 5 0 3 1 0 3 0
3 1 4 0 2 1 0 2 0
3 1 1 8 0 1 1 3 8
3 1 1 9 0 1 2 2 9
3 1 5 0 1 1 0 1 0
3 1 0 a 0 1 1 1 a
3 1 1 a 0 1 2 1 a
3 1 5 0 0 1 0 0 0
3 1 5 0 3 1 0 0 0
4 1 1 b 0 1 1 0 b
4 1 2 c 0 1 1 3 8
4 1 1 8 0 1 0 0 0
4 1 1 c 0 1 4 3 c
5 1 2 d 0 1 2 2 9
5 1 1 9 0 1 6 2 9
5 1 0 9 0 0 0 0 0
5 1 3 d 2 1 0 2 0
5 1 1 d 0 1 4 2 d
6 1 2 e 0 1 2 1 a
6 1 2 f 0 1 1 0 b
6 1 2 7 0 0 0 0 0
6 1 5 0 3 1 0 3 0
6 1 2 7 0 1 1 3 c
6 1 2 6 0 0 0 0 0
6 1 4 0 2 1 0 2 0
6 1 2 6 0 1 2 2 d
6 1 2 5 0 0 0 0 0
6 1 3 5 1 1 0 1 0
6 1 2 3 0 0 0 0 0
6 1 5 0 1 1 0 1 0
6 1 2 3 0 1 1 1 5

// ==== tb.f ====
+incdir+include
verilog/list_pkg.sv
verilog/acc_decode.sv
verilog/tag_state.sv
verilog/lru_lists.sv
verilog/acc_result.sv
verilog/list_ctrl_top.sv
dv/list_ctrl_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check sim.log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module list_ctrl_tb \
		-f tb.f -Mdir obj_dir -o list_ctrl_sim
	./obj_dir/list_ctrl_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
